//--- moving_avg_filter.sv
// Moving-average filter with a 16-deep sample history, a sum stage and a divide stage.
`timescale 1ns/1ps

module moving_avg_filter import pwm_smoother_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  sample_t  sample,
	input  logic     sample_valid,
	input  logic     hist_clr,
	input  win_sel_t win_sel,
	output sample_t  avg,
	output logic     avg_valid
);

	sample_t          hist [HIST_DEPTH];   // Entry 0 is the newest.
	logic [SUM_W-1:0] sum_next;
	logic [SUM_W-1:0] sum_q;
	logic [2:0]       shift_q;
	logic [4:0]       taps;
	logic             sum_valid;

	// Log2 of the window length.
	function automatic logic [2:0] win_shift(win_sel_t sel);
		case (sel)
			WIN_1:   return 3'd0;
			WIN_2:   return 3'd1;
			WIN_4:   return 3'd2;
			WIN_8:   return 3'd3;
			default: return 3'd4;       // WIN_16 and the spare codes.
		endcase
	endfunction

	// ************************************************************
	// Sample history
	// ************************************************************
	always_ff @(posedge clk) begin
		if (!rst_n || hist_clr) begin
			for (int i = 0; i < HIST_DEPTH; i++)
				hist[i] <= '0;
		end else if (sample_valid) begin
			hist[0] <= sample;
			for (int i = 1; i < HIST_DEPTH; i++)
				hist[i] <= hist[i-1];
		end
	end

	// ************************************************************
	// Stage one: sum of the new sample and the newest N-1 entries
	// ************************************************************
	assign taps = (5'd1 << win_shift(win_sel)) - 5'd1;

	always_comb begin
		sum_next = SUM_W'(sample);
		for (int i = 0; i < HIST_DEPTH - 1; i++) begin
			if (i < taps)
				sum_next = sum_next + SUM_W'(hist[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (sample_valid) begin
			sum_q   <= sum_next;
			shift_q <= win_shift(win_sel);   // Window held with its sum.
		end
	end

	// ************************************************************
	// Stage two: divide by the window length
	// ************************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sum_valid <= 1'b0;
			avg_valid <= 1'b0;
			avg       <= '0;
		end else begin
			sum_valid <= sample_valid;
			avg_valid <= sum_valid;
			if (sum_valid)
				avg <= sample_t'(sum_q >> shift_q);   // Truncating mean.
		end
	end

	a_avg_latency: assert property (@(posedge clk) disable iff (!rst_n)
		avg_valid == $past(sample_valid, 2));

endmodule

//--- pwm_gen.sv
// Free-running PWM generator with a duty value latched at each period wrap.
`timescale 1ns/1ps

module pwm_gen import pwm_smoother_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  duty_t duty,
	input  logic  pwm_en,
	output logic  pwm_out
);

	logic [PWM_CNT_W-1:0] cnt;
	duty_t                duty_q;
	logic                 wrap;

	assign wrap = (cnt == PWM_CNT_W'(PWM_PERIOD - 1));

	// ************************************************************
	// Period counter and output
	// ************************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt     <= '0;
			duty_q  <= '0;
			pwm_out <= 1'b0;
		end else begin
			if (wrap) begin
				cnt    <= '0;
				duty_q <= duty;            // New duty only at a period boundary.
			end else begin
				cnt <= cnt + 1'b1;
			end
			// Duty 0 never satisfies the compare.
			pwm_out <= pwm_en && (cnt < duty_q);
		end
	end

	a_pwm_off: assert property (@(posedge clk) disable iff (!rst_n)
		!pwm_en |=> !pwm_out);

endmodule

//--- pwm_smoother_pkg.sv
// Shared widths, sample and bus types, window codes, register map and PWM period.
package pwm_smoother_pkg;

	// ************************************************************
	// Widths and sizes
	// ************************************************************
	localparam int SAMPLE_W    = 16;
	localparam int ADR_W       = 2;
	localparam int DUTY_W      = 8;
	localparam int HIST_DEPTH  = 16;
	localparam int FILL_W      = $clog2(HIST_DEPTH) + 1;     // Counts 0 to 16.
	localparam int SUM_W       = SAMPLE_W + $clog2(HIST_DEPTH);
	localparam int CTRL_WIN_W  = 3;
	localparam int CTRL_EN_BIT = 4;
	localparam int PWM_PERIOD  = 256;                        // Clocks per PWM period.
	localparam int PWM_CNT_W   = $clog2(PWM_PERIOD);

	// ************************************************************
	// Types
	// ************************************************************
	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [ADR_W-1:0]    wb_adr_t;
	typedef logic [DUTY_W-1:0]   duty_t;
	typedef logic [FILL_W-1:0]   fill_t;

	// Codes 5 to 7 behave as WIN_16.
	typedef enum logic [CTRL_WIN_W-1:0] {
		WIN_1  = 3'd0,
		WIN_2  = 3'd1,
		WIN_4  = 3'd2,
		WIN_8  = 3'd3,
		WIN_16 = 3'd4
	} win_sel_t;

	// ************************************************************
	// Register map
	// ************************************************************
	localparam wb_adr_t REG_CTRL   = 2'd0;   // Window code and PWM enable.
	localparam wb_adr_t REG_SAMPLE = 2'd1;
	localparam wb_adr_t REG_RESULT = 2'd2;
	localparam wb_adr_t REG_STATUS = 2'd3;   // Fill count.

endpackage

//--- pwm_smoother_top.f
pwm_smoother_pkg.sv
moving_avg_filter.sv
pwm_gen.sv
smoother_ctrl.sv
pwm_smoother_top.sv
tb_pwm_smoother.sv

//--- pwm_smoother_top.sv
// Top level of the PWM smoother joining the bus control, the filter and the PWM generator.
`timescale 1ns/1ps

module pwm_smoother_top import pwm_smoother_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    wb_cyc,
	input  logic    wb_stb,
	input  logic    wb_we,
	input  wb_adr_t wb_adr,
	input  sample_t wb_dat_w,
	output sample_t wb_dat_r,
	output logic    wb_ack,
	output logic    pwm_out
);

	sample_t  sample;
	sample_t  avg;
	logic     sample_valid;
	logic     hist_clr;
	logic     avg_valid;
	logic     pwm_en;
	win_sel_t win_sel;
	duty_t    duty;

	// Upper byte of the average sets the duty.
	assign duty = avg[SAMPLE_W-1 -: DUTY_W];

	// ************************************************************
	// Bus slave and sequencer
	// ************************************************************
	smoother_ctrl smoother_ctrl_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.avg          (avg),
		.avg_valid    (avg_valid),
		.sample       (sample),
		.sample_valid (sample_valid),
		.hist_clr     (hist_clr),
		.win_sel      (win_sel),
		.pwm_en       (pwm_en)
	);

	// ************************************************************
	// Datapath
	// ************************************************************
	moving_avg_filter moving_avg_filter_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.sample       (sample),
		.sample_valid (sample_valid),
		.hist_clr     (hist_clr),
		.win_sel      (win_sel),
		.avg          (avg),
		.avg_valid    (avg_valid)
	);

	pwm_gen pwm_gen_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.duty    (duty),
		.pwm_en  (pwm_en),
		.pwm_out (pwm_out)
	);

endmodule

//--- smoother_ctrl.sv
// Wishbone classic slave with CTRL and fill-count registers and the filter sequencer FSM.
`timescale 1ns/1ps

module smoother_ctrl import pwm_smoother_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_adr_t  wb_adr,
	input  sample_t  wb_dat_w,
	output sample_t  wb_dat_r,
	output logic     wb_ack,
	input  sample_t  avg,
	input  logic     avg_valid,
	output sample_t  sample,
	output logic     sample_valid,
	output logic     hist_clr,
	output win_sel_t win_sel,
	output logic     pwm_en
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_AVG,
		ACK
	} state_t;

	state_t     state;
	fill_t      fill;
	logic [1:0] pending;       // Results still inside the filter.
	logic       req;
	logic       wr_sample;
	logic       wr_ctrl;
	logic       rd_result;
	logic       result_wait;
	logic       accept;
	logic       capture;
	sample_t    rd_data;

	// ************************************************************
	// Bus decode
	// ************************************************************
	assign req       = wb_cyc && wb_stb;
	assign wr_sample = wb_we && (wb_adr == REG_SAMPLE);
	assign wr_ctrl   = wb_we && (wb_adr == REG_CTRL);
	assign rd_result = !wb_we && (wb_adr == REG_RESULT);

	// A result arriving this very cycle is already usable.
	assign result_wait = (pending != 2'd0) && !(avg_valid && (pending == 2'd1));

	assign accept  = (state == IDLE) && req && !(rd_result && result_wait);
	assign capture = accept || ((state == WAIT_AVG) && avg_valid && (pending == 2'd1));

	assign wb_ack = (state == ACK);

	always_comb begin
		rd_data = '0;
		case (wb_adr)
			REG_CTRL: begin
				rd_data[CTRL_WIN_W-1:0] = win_sel;
				rd_data[CTRL_EN_BIT]    = pwm_en;
			end
			REG_SAMPLE: rd_data = sample;
			REG_RESULT: rd_data = avg;
			REG_STATUS: rd_data[FILL_W-1:0] = fill;
		endcase
	end

	// ************************************************************
	// Sequencer FSM and CTRL register
	// ************************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= IDLE;
			sample_valid <= 1'b0;
			hist_clr     <= 1'b0;
			win_sel      <= WIN_1;
			pwm_en       <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			hist_clr     <= 1'b0;
			case (state)
				IDLE: begin
					if (accept) begin
						state        <= ACK;
						sample_valid <= wr_sample;   // Pulses in the ack cycle.
						if (wr_ctrl) begin
							win_sel  <= win_sel_t'(wb_dat_w[CTRL_WIN_W-1:0]);
							pwm_en   <= wb_dat_w[CTRL_EN_BIT];
							hist_clr <= (wb_dat_w[CTRL_WIN_W-1:0] != win_sel);
						end
					end else if (req) begin
						state <= WAIT_AVG;             // RESULT read behind a pending sample.
					end
				end
				WAIT_AVG: begin
					if (capture)
						state <= ACK;
				end
				ACK: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Read data and outgoing sample.
	always_ff @(posedge clk) begin
		if (accept && wr_sample)
			sample <= wb_dat_w;
		if (capture)
			wb_dat_r <= rd_data;
	end

	// ************************************************************
	// Pending results and fill count
	// ************************************************************
	always_ff @(posedge clk) begin
		if (!rst_n)
			pending <= 2'd0;
		else if (sample_valid && !avg_valid)
			pending <= pending + 2'd1;
		else if (!sample_valid && avg_valid)
			pending <= pending - 2'd1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || hist_clr)
			fill <= '0;
		else if (sample_valid && (fill != fill_t'(HIST_DEPTH)))
			fill <= fill + 1'b1;          // Saturates at the history depth.
	end

	// ************************************************************
	// Assertions
	// ************************************************************
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb));

	a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(sample_valid && hist_clr));

endmodule

//--- tb_pwm_smoother.sv
// Testbench for the PWM smoother with bus tasks, a stimulus table, a reference model and checks.
`timescale 1ns/1ps

module tb_pwm_smoother import pwm_smoother_pkg::*; ();

	logic    clk;
	logic    rst_n;
	logic    wb_cyc;
	logic    wb_stb;
	logic    wb_we;
	wb_adr_t wb_adr;
	sample_t wb_dat_w;
	sample_t wb_dat_r;
	logic    wb_ack;
	logic    pwm_out;

	// Stimulus table with one entry per row.
	logic [2:0] row_code [$];
	sample_t    row_smp [$];
	bit         row_rnd [$];      // Row draws its samples from $random.
	int         row_rep [$];      // Samples written for the row.
	fill_t      row_fill [$];     // STATUS after the last sample of the row.

	sample_t    hist_q [$];       // Model history with the newest entry first.
	integer     seed;
	int         value_errs;
	int         other_errs;
	int         cycle_cnt;
	int         timeout_limit;
	int         total_samples;
	logic [2:0] cur_code;
	sample_t    rd;
	sample_t    smp;
	sample_t    avg_now;
	fill_t      last_fill;

	pwm_smoother_top pwm_smoother_top_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.pwm_out  (pwm_out)
	);

	always #20 clk = ~clk;

	// ************************************************************
	// Bus tasks
	// ************************************************************
	task automatic wait_ack(input bit one_cycle);
		int waits;
		waits = 1;
		@(negedge clk);
		while (!wb_ack) begin
			@(negedge clk);
			waits++;
		end
		if (one_cycle && waits != 1) begin
			other_errs++;
			$display("wb_ack came %0d cycles after stb instead of one cycle", waits);
		end
	endtask

	// The slave acks for a single cycle.
	task automatic ack_dropped();
		if (wb_ack !== 1'b0) begin
			other_errs++;
			$display("wb_ack stayed high for more than one cycle");
		end
	endtask

	task automatic wb_write(input wb_adr_t adr, input sample_t data);
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = data;
		wait_ack(1'b1);
		@(negedge clk);                // Held through the edge that sees ack.
		ack_dropped();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input wb_adr_t adr, output sample_t data);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		wait_ack(adr != REG_RESULT);
		data = wb_dat_r;
		@(negedge clk);
		ack_dropped();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// ************************************************************
	// Reference model
	// ************************************************************
	function automatic sample_t ctrl_word(input logic [2:0] code, input logic en);
		sample_t w;
		w      = '0;
		w[2:0] = code;
		w[4]   = en;
		return w;
	endfunction

	task automatic push_history(input sample_t s);
		hist_q.push_front(s);
		if (hist_q.size() > 16)
			hist_q.pop_back();
	endtask

	// Truncated mean of the newest N entries with missing entries as zero.
	function automatic sample_t window_mean(input logic [2:0] code);
		int unsigned n;
		int unsigned sum;
		n   = (code >= 3'd4) ? 16 : (1 << code);
		sum = 0;
		for (int i = 0; i < n && i < hist_q.size(); i++)
			sum += hist_q[i];
		return sample_t'(sum / n);
	endfunction

	function automatic fill_t fill_level();
		return fill_t'(hist_q.size());
	endfunction

	// ************************************************************
	// Compare tasks
	// ************************************************************
	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			value_errs++;
			$display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
		end
	endtask

	task automatic check_fill(input string name, input fill_t exp, input fill_t act);
		if (act !== exp) begin
			value_errs++;
			$display("FAIL %s: expected 0x%h, got 0x%h", name, exp, act);
		end
	endtask

	// Counts high clocks of pwm_out over a window of clocks.
	task automatic check_pwm(input duty_t exp, input int cycles);
		int high;
		high = 0;
		repeat (cycles) begin
			@(negedge clk);
			if (pwm_out === 1'b1)
				high++;
		end
		if (high != int'(exp)) begin
			value_errs++;
			$display("FAIL pwm_out high clocks: expected 0x%h, got 0x%h", exp, high);
		end
	endtask

	task automatic add_row(input logic [2:0] code, input sample_t s, input bit rnd,
			input int rep, input fill_t fill);
		row_code.push_back(code);
		row_smp.push_back(s);
		row_rnd.push_back(rnd);
		row_rep.push_back(rep);
		row_fill.push_back(fill);
	endtask

	task automatic load_table();
		add_row(3'd0, 16'h1234, 1'b0, 1, 5'd1);    // WIN_1 pass-through.
		add_row(3'd0, 16'hFFFF, 1'b0, 1, 5'd2);
		add_row(3'd0, 16'h8001, 1'b0, 1, 5'd3);
		add_row(3'd1, 16'h0003, 1'b0, 1, 5'd1);
		add_row(3'd1, 16'h0004, 1'b0, 1, 5'd2);
		add_row(3'd1, 16'hFFFF, 1'b0, 1, 5'd3);
		add_row(3'd2, 16'h0000, 1'b1, 5, 5'd5);
		add_row(3'd3, 16'hFFFF, 1'b0, 4, 5'd4);
		add_row(3'd3, 16'h0000, 1'b1, 6, 5'd10);   // Same code keeps the history.
		add_row(3'd4, 16'hFFFF, 1'b0, 16, 5'd16);  // Full-scale sum.
		add_row(3'd4, 16'h0000, 1'b1, 4, 5'd16);
		add_row(3'd5, 16'h0000, 1'b1, 3, 5'd3);
		add_row(3'd6, 16'hA5A5, 1'b0, 2, 5'd2);
		add_row(3'd7, 16'h0000, 1'b1, 17, 5'd16);
		add_row(3'd4, 16'hC350, 1'b0, 16, 5'd16);  // Steady average for the PWM.
	endtask

	// ************************************************************
	// Timeout
	// ************************************************************
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_limit) begin
			other_errs++;
			$display("Timeout: the run did not finish within %0d clock cycles.", timeout_limit);
			$display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
			$display("Test failed");
			$finish;
		end
	end

	// ************************************************************
	// Stimulus
	// ************************************************************
	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		seed       = 86;
		value_errs = 0;
		other_errs = 0;
		cycle_cnt  = 0;
		load_table();
		total_samples = 0;
		foreach (row_rep[r])
			total_samples += row_rep[r];
		timeout_limit = 2 * (total_samples * 40 + 6 * PWM_PERIOD);

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Reset state and CTRL readback.
		wb_read(REG_RESULT, rd);
		check_sample("RESULT", 16'h0000, rd);
		wb_read(REG_STATUS, rd);
		check_fill("STATUS", 5'd0, rd[FILL_W-1:0]);
		wb_read(REG_CTRL, rd);
		check_sample("CTRL", 16'h0000, rd);
		wb_write(REG_CTRL, 16'hFFFF);
		cur_code = 3'd7;
		hist_q.delete();
		wb_read(REG_CTRL, rd);
		check_sample("CTRL", ctrl_word(3'd7, 1'b1), rd);

		foreach (row_code[r]) begin
			if (row_code[r] != cur_code) begin
				wb_write(REG_CTRL, ctrl_word(row_code[r], 1'b0));
				cur_code = row_code[r];
				hist_q.delete();                   // Window change clears the history.
			end
			for (int k = 0; k < row_rep[r]; k++) begin
				smp = row_rnd[r] ? sample_t'($random(seed)) : row_smp[r];
				wb_write(REG_SAMPLE, smp);
				push_history(smp);
				wb_read(REG_RESULT, rd);
				check_sample("RESULT", window_mean(cur_code), rd);
				wb_read(REG_STATUS, rd);
				last_fill = rd[FILL_W-1:0];
				check_fill("STATUS", fill_level(), last_fill);
			end
			check_fill("STATUS", row_fill[r], last_fill);
		end

		// Same code with the enable set must keep the history.
		wb_write(REG_CTRL, ctrl_word(cur_code, 1'b1));
		wb_read(REG_STATUS, rd);
		check_fill("STATUS", fill_level(), rd[FILL_W-1:0]);
		avg_now = window_mean(cur_code);
		wb_read(REG_RESULT, rd);
		check_sample("RESULT", avg_now, rd);
		wb_read(REG_CTRL, rd);
		check_sample("CTRL", ctrl_word(cur_code, 1'b1), rd);

		repeat (2 * PWM_PERIOD) @(negedge clk);   // Lets a wrap latch the duty.
		check_pwm(avg_now[15:8], PWM_PERIOD);

		wb_write(REG_CTRL, ctrl_word(cur_code, 1'b0));
		@(negedge clk);
		check_pwm(8'h00, 2 * PWM_PERIOD);

		$display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
